// File: weight_replay_top.f
+incdir+verif
verilog/replay_cfg_pkg.sv
verilog/replay_regs_pkg.sv
verilog/weight_if.sv
verilog/wb_weight_loader.sv
verilog/cyclic_bram.sv
verilog/dot_product_engine.sv
verilog/weight_replay_top.sv
verif/tb_weight_replay.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the weight replay testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_weight_replay -f weight_replay_top.f -Mdir obj_dir

./obj_dir/Vtb_weight_replay | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
  exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

// File: verif/tb_wb_tasks.svh
/*
  Wishbone classic master tasks, one access at a time.
  Inputs change 1 ns after the rising edge, ack and read data are taken
  on the falling edge. A missing ack ends the run through report_timeout.
*/
`ifndef TB_WB_TASKS_SVH
`define TB_WB_TASKS_SVH

  task automatic bus_cycle(input logic we,
                           input logic [replay_cfg_pkg::WB_ADR_W-1:0] adr,
                           input logic [replay_cfg_pkg::WB_DAT_W-1:0] wdata,
                           output logic [replay_cfg_pkg::WB_DAT_W-1:0] rdata);
    int waited;
    @(posedge clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_wdata = wdata;
    waited   = 0;
    @(negedge clk);
    while (!wb_ack) begin
      if (waited == WB_TIMEOUT) begin
        report_timeout("wishbone ack");
      end
      waited++;
      @(negedge clk);
    end
    rdata = wb_rdata;  // registered together with the ack.
    @(posedge clk);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic write_reg(input logic [replay_cfg_pkg::WB_ADR_W-1:0] adr,
                           input logic [replay_cfg_pkg::WB_DAT_W-1:0] data);
    logic [replay_cfg_pkg::WB_DAT_W-1:0] ignored;
    bus_cycle(1'b1, adr, data, ignored);
  endtask

  task automatic read_reg(input logic [replay_cfg_pkg::WB_ADR_W-1:0] adr,
                          output logic [replay_cfg_pkg::WB_DAT_W-1:0] data);
    bus_cycle(1'b0, adr, 32'h0, data);
  endtask

`endif

// File: verif/tb_weight_replay.sv
/*
  Testbench for weight_replay_top.
  Each table row reloads the buffer, replays N_WIN windows and checks
  every result against a model of the pointer rules and the MAC.
  Addresses a row reads must have been written by that row or an earlier one.
*/
`timescale 1ns/1ps

module tb_weight_replay;

  localparam int N_WIN          = 3;  // windows checked per row.
  localparam int MAX_ACTS       = N_WIN * replay_cfg_pkg::DEPTH;
  localparam int SEED           = 39176;
  localparam int WB_TIMEOUT     = 20;
  localparam int STREAM_TIMEOUT = 500;  // cycles between two results.

  typedef struct packed {
    int win_min;
    int win_max;
    int n_weights;
    int act_ofs;  // added to the seed for the activations of the row.
    bit stall;    // result_ready drops for random stretches.
    bit drop;     // weight writes while run is set.
  } case_t;

  localparam int N_CASES = 5;
  localparam case_t CASES [N_CASES] = '{
    '{0, 7, 8, 1, 1'b0, 1'b0},
    '{2, 5, 5, 2, 1'b0, 1'b0},  // address 5 keeps its weight from row 0.
    '{0, 7, 8, 3, 1'b1, 1'b0},
    '{1, 4, 3, 4, 1'b0, 1'b1},
    '{3, 12, 13, 5, 1'b1, 1'b0}
  };

  logic                                clk;
  logic                                rst;
  logic                                wb_cyc;
  logic                                wb_stb;
  logic                                wb_we;
  logic [replay_cfg_pkg::WB_ADR_W-1:0] wb_adr;
  logic [replay_cfg_pkg::WB_DAT_W-1:0] wb_wdata;
  logic [replay_cfg_pkg::WB_DAT_W-1:0] wb_rdata;
  logic                                wb_ack;
  logic                                act_valid;
  logic                                act_ready;
  logic [replay_cfg_pkg::ACT_W-1:0]    act_data;
  logic                                result_valid;
  logic                                result_ready;
  logic [replay_cfg_pkg::ACC_W-1:0]    result_data;

  int seed;
  int act_seed;
  int errors;
  int n_checks;
  int mdl_wr_ptr;  // model of the buffer write pointer.
  logic [replay_cfg_pkg::WEIGHT_W-1:0] mdl_mem [replay_cfg_pkg::DEPTH];
  logic [replay_cfg_pkg::ACT_W-1:0]    acts [MAX_ACTS];
  logic [replay_cfg_pkg::ACC_W-1:0]    exp_res [N_WIN];

  weight_replay_top i_dut (.*);

  always #5 clk = ~clk;

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    assert (got == exp) else begin
      errors++;
      $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("checks: %0d, errors: %0d", n_checks, errors);
    if (errors == 0) $display("STATUS: PASS");
    else $display("STATUS: FAIL");
    $finish;
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("TIMEOUT at %0t ns: no %s within the time limit", $time, what);
    finish_run();
  endtask

  `include "tb_wb_tasks.svh"

  task automatic load_case(input case_t c);
    logic [replay_cfg_pkg::WEIGHT_W-1:0] w;
    logic [replay_cfg_pkg::WB_DAT_W-1:0] rdata;
    logic [replay_cfg_pkg::WB_DAT_W-1:0] exp_word;
    write_reg(replay_regs_pkg::REG_CTRL, 32'h2);  // stop replay and clear.
    mdl_wr_ptr = 0;
    write_reg(replay_regs_pkg::REG_WINDOW,
              replay_cfg_pkg::WB_DAT_W'((c.win_max << 8) | c.win_min));
    for (int i = 0; i < c.n_weights; i++) begin
      w = replay_cfg_pkg::WEIGHT_W'($random(seed));
      write_reg(replay_regs_pkg::REG_WEIGHT, replay_cfg_pkg::WB_DAT_W'(w));
      mdl_mem[mdl_wr_ptr] = w;
      mdl_wr_ptr = (mdl_wr_ptr < c.win_max) ? mdl_wr_ptr + 1 : 0;
    end
    exp_word       = '0;  // run low, write pointer in bits 11:8.
    exp_word[11:8] = replay_cfg_pkg::ADDR_W'(mdl_wr_ptr);
    read_reg(replay_regs_pkg::REG_STATUS, rdata);
    check_value("status after load", rdata, exp_word);
    exp_word       = '0;
    exp_word[3:0]  = replay_cfg_pkg::ADDR_W'(c.win_min);
    exp_word[11:8] = replay_cfg_pkg::ADDR_W'(c.win_max);
    read_reg(replay_regs_pkg::REG_WINDOW, rdata);
    check_value("window readback", rdata, exp_word);
    write_reg(replay_regs_pkg::REG_CTRL, 32'h3);  // run, replay starts at win_min.
    if (c.drop) begin
      for (int i = 0; i < 3; i++) begin
        write_reg(replay_regs_pkg::REG_WEIGHT, replay_cfg_pkg::WB_DAT_W'($random(seed)));
      end
      // the clear zeroed the pointer and dropped writes leave it there.
      read_reg(replay_regs_pkg::REG_STATUS, rdata);
      check_value("status after dropped writes", rdata, 32'h1);
    end
  endtask

  // window w pairs addresses win_min..win_max with activations w*len onward.
  function automatic int build_expect(input case_t c);
    int len;
    len = c.win_max - c.win_min + 1;
    act_seed = SEED + c.act_ofs;
    for (int k = 0; k < N_WIN * len; k++) begin
      acts[k] = replay_cfg_pkg::ACT_W'($random(act_seed));
    end
    for (int w = 0; w < N_WIN; w++) begin
      exp_res[w] = '0;
      for (int j = 0; j < len; j++) begin
        exp_res[w] = exp_res[w] + replay_cfg_pkg::ACC_W'(mdl_mem[c.win_min + j])
                   * replay_cfg_pkg::ACC_W'(acts[w * len + j]);
      end
    end
    return N_WIN * len;
  endfunction

  task automatic run_stream(input bit stall, input int n_acts);
    int  act_idx;
    int  n_res;
    int  waited;
    int  hold;
    bit  act_fire;
    bit  res_fire;
    act_idx      = 0;
    n_res        = 0;
    waited       = 0;
    hold         = 0;
    act_valid    = 1'b1;
    act_data     = acts[0];
    result_ready = 1'b1;
    while (n_res < N_WIN) begin
      @(negedge clk);  // handshakes are stable here until the next edge.
      act_fire = act_valid && act_ready;
      res_fire = result_valid && result_ready;
      if (res_fire) begin
        check_value($sformatf("window %0d result", n_res), 32'(result_data),
                    32'(exp_res[n_res]));
        n_res++;
        waited = 0;
      end else if (waited == STREAM_TIMEOUT) begin
        report_timeout("result from the engine");
      end else begin
        waited++;
      end
      @(posedge clk);
      #1;
      if (act_fire) act_idx++;
      act_valid = (act_idx < n_acts);
      if (act_idx < n_acts) act_data = acts[act_idx];
      if (stall && hold == 0 && ($random(seed) & 7) == 0) begin
        hold = 2 + ($random(seed) & 7);
      end
      if (hold > 0) begin
        result_ready = 1'b0;
        hold--;
      end else begin
        result_ready = 1'b1;
      end
    end
    act_valid    = 1'b0;
    result_ready = 1'b0;
  endtask

  initial begin
    int n_acts;
    clk          = 1'b0;
    rst          = 1'b1;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_wdata     = '0;
    act_valid    = 1'b0;
    act_data     = '0;
    result_ready = 1'b0;
    seed         = SEED;
    errors       = 0;
    n_checks     = 0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int r = 0; r < N_CASES; r++) begin
      load_case(CASES[r]);
      n_acts = build_expect(CASES[r]);
      run_stream(CASES[r].stall, n_acts);
    end
    finish_run();
  end

endmodule

// File: verilog/weight_replay_top.sv
/*
  Weight replay block: wishbone loader, cyclic buffer and dot product engine.
  Host port is wishbone classic; activations and results are
  valid/ready streams. All ports are synchronous to clk.
*/
`timescale 1ns/1ps

module weight_replay_top (
  input  logic                                clk,
  input  logic                                rst,

  input  logic                                wb_cyc,
  input  logic                                wb_stb,
  input  logic                                wb_we,
  input  logic [replay_cfg_pkg::WB_ADR_W-1:0] wb_adr,
  input  logic [replay_cfg_pkg::WB_DAT_W-1:0] wb_wdata,
  output logic [replay_cfg_pkg::WB_DAT_W-1:0] wb_rdata,
  output logic                                wb_ack,

  input  logic                                act_valid,
  output logic                                act_ready,
  input  logic [replay_cfg_pkg::ACT_W-1:0]    act_data,

  output logic                                result_valid,
  input  logic                                result_ready,
  output logic [replay_cfg_pkg::ACC_W-1:0]    result_data
);

  logic [replay_cfg_pkg::ADDR_W-1:0] wr_ptr;  // status readback only.

  weight_wr_if wr_bus ();
  weight_rd_if rd_bus ();

  wb_weight_loader i_loader (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_wdata (wb_wdata),
    .wr_ptr   (wr_ptr),
    .wb_rdata (wb_rdata),
    .wb_ack   (wb_ack),
    .wr       (wr_bus.loader)
  );

  cyclic_bram i_buffer (
    .clk    (clk),
    .rst    (rst),
    .wr_ptr (wr_ptr),
    .wr     (wr_bus.buffer),
    .rd     (rd_bus.buffer)
  );

  dot_product_engine i_engine (
    .clk          (clk),
    .rst          (rst),
    .act_valid    (act_valid),
    .act_data     (act_data),
    .act_ready    (act_ready),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .result_data  (result_data),
    .rd           (rd_bus.engine)
  );

endmodule

// File: verilog/dot_product_engine.sv
/*
  Unsigned multiply-accumulate over one replay window.
  A weight and an activation move only together, and only while the FSM
  accumulates. One sum per window is held until result_ready.
*/
`timescale 1ns/1ps

module dot_product_engine (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             act_valid,
  input  logic [replay_cfg_pkg::ACT_W-1:0] act_data,
  output logic                             act_ready,
  output logic                             result_valid,
  input  logic                             result_ready,
  output logic [replay_cfg_pkg::ACC_W-1:0] result_data,
  weight_rd_if.engine                      rd
);

  replay_regs_pkg::mac_state_e state;
  logic                                                     fire;
  logic [replay_cfg_pkg::WEIGHT_W+replay_cfg_pkg::ACT_W-1:0] product;
  logic [replay_cfg_pkg::ACC_W-1:0]                         acc;

  // joint handshake, both sides move on the same cycle or neither does.
  assign fire      = (state == replay_regs_pkg::MAC_ACC) && rd.valid && act_valid;
  assign act_ready = fire;
  assign rd.ready  = fire;

  assign product = rd.data * act_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= replay_regs_pkg::MAC_ACC;
      acc          <= '0;
      result_valid <= 1'b0;
    end else begin
      case (state)
        replay_regs_pkg::MAC_ACC: begin
          if (fire) begin
            acc <= acc + replay_cfg_pkg::ACC_W'(product);
            if (rd.last) begin
              state        <= replay_regs_pkg::MAC_EMIT;  // the sum is complete.
              result_valid <= 1'b1;
            end
          end
        end
        replay_regs_pkg::MAC_EMIT: begin
          if (result_ready) begin
            state        <= replay_regs_pkg::MAC_ACC;
            result_valid <= 1'b0;
            acc          <= '0;  // start the next window from zero.
          end
        end
        default: state <= replay_regs_pkg::MAC_ACC;
      endcase
    end
  end

  // the accumulator holds still in MAC_EMIT, so it is the result.
  assign result_data = acc;

endmodule

// File: verilog/cyclic_bram.sv
/*
  Cyclic weight buffer on an inferred single-port memory.
  Words are written in order; while run is set the window from addr_min
  to addr_max is replayed forever as an always-valid stream.
  A write takes the memory port, so no read is issued in that cycle.
*/
`timescale 1ns/1ps

module cyclic_bram (
  input  logic                              clk,
  input  logic                              rst,
  output logic [replay_cfg_pkg::ADDR_W-1:0] wr_ptr,
  weight_wr_if.buffer                       wr,
  weight_rd_if.buffer                       rd
);

  logic [replay_cfg_pkg::WEIGHT_W-1:0] mem [replay_cfg_pkg::DEPTH];
  logic [replay_cfg_pkg::WEIGHT_W-1:0] mem_q;
  logic [replay_cfg_pkg::ADDR_W-1:0]   rd_ptr;
  logic [replay_cfg_pkg::ADDR_W-1:0]   rd_cur;
  logic [replay_cfg_pkg::ADDR_W-1:0]   addr;
  logic issue;
  logic push;
  logic pop;
  logic rd_pend;    // a read was issued last cycle, its data is in mem_q.
  logic pend_last;  // last flag of that read.

  logic [replay_cfg_pkg::WEIGHT_W-1:0]   fifo_data [replay_cfg_pkg::FIFO_DEPTH];
  logic [replay_cfg_pkg::FIFO_DEPTH-1:0] fifo_last;
  logic [replay_cfg_pkg::FIFO_AW-1:0]    fifo_wr_idx;
  logic [replay_cfg_pkg::FIFO_AW-1:0]    fifo_rd_idx;
  logic [replay_cfg_pkg::FIFO_CNT_W-1:0] fifo_cnt;
  logic [replay_cfg_pkg::FIFO_CNT_W-1:0] in_flight;  // FIFO entries plus pending reads.

  // a clear restarts the window at addr_min in the same cycle, so run and
  // clear written together still give the first valid two cycles later.
  assign rd_cur = wr.clear ? wr.addr_min : rd_ptr;
  assign addr   = wr.wr_en ? wr_ptr : rd_cur;

  assign pop  = rd.valid && rd.ready;
  assign push = rd_pend;

  // only read when the FIFO is sure to have room for the data.
  assign issue = wr.run && !wr.wr_en &&
                 (wr.clear || pop ||
                  in_flight < replay_cfg_pkg::FIFO_CNT_W'(replay_cfg_pkg::FIFO_DEPTH));

  always_ff @(posedge clk) begin
    if (wr.wr_en) mem[addr] <= wr.wr_data;
    mem_q <= mem[addr];  // read-first, ignored on write cycles.
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      rd_pend     <= 1'b0;
      in_flight   <= '0;
      fifo_cnt    <= '0;
      fifo_wr_idx <= '0;
      fifo_rd_idx <= '0;
    end else begin
      if (wr.clear) wr_ptr <= '0;
      else if (wr.wr_en) wr_ptr <= (wr_ptr < wr.addr_max) ? wr_ptr + 1'b1 : '0;

      if (issue) rd_ptr <= (rd_cur < wr.addr_max) ? rd_cur + 1'b1 : wr.addr_min;
      else if (wr.clear) rd_ptr <= wr.addr_min;

      rd_pend <= issue;

      if (wr.clear) begin
        // drop the FIFO and any read issued before the clear.
        in_flight   <= replay_cfg_pkg::FIFO_CNT_W'(issue);
        fifo_cnt    <= '0;
        fifo_wr_idx <= '0;
        fifo_rd_idx <= '0;
      end else begin
        in_flight <= in_flight + replay_cfg_pkg::FIFO_CNT_W'(issue)
                   - replay_cfg_pkg::FIFO_CNT_W'(pop);
        fifo_cnt  <= fifo_cnt + replay_cfg_pkg::FIFO_CNT_W'(push)
                   - replay_cfg_pkg::FIFO_CNT_W'(pop);
        if (push) begin
          fifo_wr_idx <= (fifo_wr_idx == replay_cfg_pkg::FIFO_AW'(replay_cfg_pkg::FIFO_DEPTH - 1))
                       ? '0 : fifo_wr_idx + 1'b1;
        end
        if (pop) begin
          fifo_rd_idx <= (fifo_rd_idx == replay_cfg_pkg::FIFO_AW'(replay_cfg_pkg::FIFO_DEPTH - 1))
                       ? '0 : fifo_rd_idx + 1'b1;
        end
      end
    end
  end

  // the last flag is computed when the read is issued and travels with the data.
  always_ff @(posedge clk) begin
    pend_last <= (rd_cur == wr.addr_max);
    if (push) begin
      fifo_data[fifo_wr_idx] <= mem_q;
      fifo_last[fifo_wr_idx] <= pend_last;
    end
  end

  assign rd.valid = (fifo_cnt != '0);
  assign rd.data  = fifo_data[fifo_rd_idx];
  assign rd.last  = fifo_last[fifo_rd_idx];

endmodule

// File: verilog/wb_weight_loader.sv
/*
  Wishbone classic slave for the weight buffer, no pipelined mode.
  Ack comes one cycle after the request and the FSM then waits for stb to
  drop, so each access takes at least three cycles.
  Weight writes while run is set are acknowledged but dropped.
*/
`timescale 1ns/1ps

module wb_weight_loader (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                wb_cyc,
  input  logic                                wb_stb,
  input  logic                                wb_we,
  input  logic [replay_cfg_pkg::WB_ADR_W-1:0] wb_adr,
  input  logic [replay_cfg_pkg::WB_DAT_W-1:0] wb_wdata,
  input  logic [replay_cfg_pkg::ADDR_W-1:0]   wr_ptr,
  output logic [replay_cfg_pkg::WB_DAT_W-1:0] wb_rdata,
  output logic                                wb_ack,
  weight_wr_if.loader                         wr
);

  replay_regs_pkg::wb_state_e state;
  replay_regs_pkg::wb_reg_e   reg_sel;
  logic [replay_cfg_pkg::WB_DAT_W-1:0] rd_word;
  logic                                accept;

  assign reg_sel = replay_regs_pkg::wb_reg_e'(wb_adr);
  assign accept  = wb_cyc && wb_stb && (state == replay_regs_pkg::WB_IDLE);

  // read data mux, sampled when the request is accepted.
  always_comb begin
    rd_word = '0;
    case (reg_sel)
      replay_regs_pkg::REG_WINDOW: begin
        rd_word[replay_regs_pkg::WIN_MIN_LSB +: replay_cfg_pkg::ADDR_W] = wr.addr_min;
        rd_word[replay_regs_pkg::WIN_MAX_LSB +: replay_cfg_pkg::ADDR_W] = wr.addr_max;
      end
      replay_regs_pkg::REG_CTRL: rd_word[replay_regs_pkg::CTRL_RUN_BIT] = wr.run;
      replay_regs_pkg::REG_STATUS: begin
        rd_word[replay_regs_pkg::STAT_RUN_BIT] = wr.run;
        rd_word[replay_regs_pkg::STAT_PTR_LSB +: replay_cfg_pkg::ADDR_W] = wr_ptr;
      end
      default: ;  // the weight register reads as zero.
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= replay_regs_pkg::WB_IDLE;
      wb_ack      <= 1'b0;
      wr.wr_en    <= 1'b0;
      wr.clear    <= 1'b0;
      wr.run      <= 1'b0;
      wr.addr_min <= '0;
      wr.addr_max <= replay_cfg_pkg::ADDR_W'(replay_cfg_pkg::DEPTH - 1);
    end else begin
      // strobes last exactly one cycle, the ack cycle.
      wb_ack   <= 1'b0;
      wr.wr_en <= 1'b0;
      wr.clear <= 1'b0;
      case (state)
        replay_regs_pkg::WB_IDLE: begin
          if (accept) begin
            state  <= replay_regs_pkg::WB_ACK;
            wb_ack <= 1'b1;
            if (wb_we) begin
              case (reg_sel)
                replay_regs_pkg::REG_WEIGHT: wr.wr_en <= !wr.run;
                replay_regs_pkg::REG_WINDOW: begin
                  wr.addr_min <= wb_wdata[replay_regs_pkg::WIN_MIN_LSB +: replay_cfg_pkg::ADDR_W];
                  wr.addr_max <= wb_wdata[replay_regs_pkg::WIN_MAX_LSB +: replay_cfg_pkg::ADDR_W];
                end
                replay_regs_pkg::REG_CTRL: begin
                  wr.run   <= wb_wdata[replay_regs_pkg::CTRL_RUN_BIT];
                  wr.clear <= wb_wdata[replay_regs_pkg::CTRL_CLEAR_BIT];
                end
                default: ;  // writes to status are ignored.
              endcase
            end
          end
        end
        replay_regs_pkg::WB_ACK: begin
          if (!(wb_cyc && wb_stb)) state <= replay_regs_pkg::WB_IDLE;  // wait for the master.
        end
        default: state <= replay_regs_pkg::WB_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wb_rdata   <= rd_word;
      wr.wr_data <= wb_wdata[replay_cfg_pkg::WEIGHT_W-1:0];
    end
  end

endmodule

// File: verilog/weight_if.sv
/*
  Internal buses of the weight replay block.
  The write side has no handshake: a word is written on every cycle with
  wr_en high, and clear is a one cycle pulse.
  The read side moves a word when valid and ready are both high.
*/
`timescale 1ns/1ps

interface weight_wr_if;
  logic                              wr_en;
  logic [replay_cfg_pkg::WEIGHT_W-1:0] wr_data;
  logic [replay_cfg_pkg::ADDR_W-1:0]   addr_min;
  logic [replay_cfg_pkg::ADDR_W-1:0]   addr_max;
  logic                              clear;
  logic                              run;  // level, replay is active while high.

  modport loader (
    output wr_en, wr_data, addr_min, addr_max, clear, run
  );

  modport buffer (
    input wr_en, wr_data, addr_min, addr_max, clear, run
  );
endinterface

interface weight_rd_if;
  logic                              valid;
  logic [replay_cfg_pkg::WEIGHT_W-1:0] data;
  logic                              last;  // word came from addr_max.
  logic                              ready;

  // valid, data and last hold while ready is low.
  modport buffer (
    output valid, data, last,
    input  ready
  );

  modport engine (
    input  valid, data, last,
    output ready
  );
endinterface

// File: verilog/replay_regs_pkg.sv
/*
  Register map, register field positions and FSM encodings.
  Register addresses are word addresses on the wishbone port.
  REG_STATUS is read-only and the clear bit of REG_CTRL self-clears.
*/
package replay_regs_pkg;

  typedef enum logic [replay_cfg_pkg::WB_ADR_W-1:0] {
    REG_WEIGHT = 2'd0,  // write pushes one weight at the write pointer.
    REG_WINDOW = 2'd1,  // replay window limits.
    REG_CTRL   = 2'd2,  // run and clear.
    REG_STATUS = 2'd3   // run and the write pointer.
  } wb_reg_e;

  // field positions inside the register words.
  localparam int WIN_MIN_LSB    = 0;
  localparam int WIN_MAX_LSB    = 8;
  localparam int CTRL_RUN_BIT   = 0;
  localparam int CTRL_CLEAR_BIT = 1;
  localparam int STAT_RUN_BIT   = 0;
  localparam int STAT_PTR_LSB   = 8;

  typedef enum logic {
    WB_IDLE = 1'b0,
    WB_ACK  = 1'b1
  } wb_state_e;

  typedef enum logic {
    MAC_ACC  = 1'b0,
    MAC_EMIT = 1'b1
  } mac_state_e;

endpackage

// File: verilog/replay_cfg_pkg.sv
/*
  Sizing constants for the weight replay block.
  Write and read widths are equal, and DEPTH must equal 2**ADDR_W.
  FIFO_DEPTH must be at least 2 so that one read can stay in flight
  while the consumer drains the previous word.
*/
package replay_cfg_pkg;

  // weight word as stored in the buffer and replayed to the engine.
  localparam int WEIGHT_W = 8;

  localparam int ACT_W = 8;  // one activation sample.

  // accumulator and result width, wide enough for a full 16 word window.
  localparam int ACC_W = 24;

  localparam int DEPTH  = 16;  // weight words held by the buffer.
  localparam int ADDR_W = 4;   // buffer address width.

  // output FIFO behind the memory; it hides the one cycle read latency.
  localparam int FIFO_DEPTH = 2;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);  // counts 0 to FIFO_DEPTH.

  // wishbone host port, addressed in words.
  localparam int WB_ADR_W = 2;
  localparam int WB_DAT_W = 32;

endpackage
